// File: vlog.f
+incdir+sim
source/sensor_pkg.sv
source/frame_timing_ctrl.sv
source/test_pattern_gen.sv
source/sync_code_insert.sv
source/line_crc.sv
source/sensor_video_top.sv
sim/tb_sensor_video.sv

// File: run_sim.sh
#!/bin/sh
# build and run the sensor video testbench with Verilator
# exit status 0 only when the log holds the pass line

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_sensor_video \
	-o tb_sensor_video
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/tb_sensor_video > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "TEST OK" "$LOG"; then
	echo "simulation passed"
	exit 0
fi
echo "pass line not found in $LOG"
exit 1

// File: sim/tb_tasks.svh
/*
  helpers included inside tb_sensor_video
  models give the counting pattern and the CRC-10 of each lane
  tasks start and end 1 time unit after a rising clock edge
*/
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
	if (got !== exp) begin
		err_cnt++;
		$display("Error: %0t: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
		stop_run();
	end
endtask

// (c*4 + k + f) mod 1024
// frame count wraps at 8 bits in the DUT
function automatic logic [sensor_pkg::PIX_W-1:0] pattern_word(input int c, input int k,
	input int f);
	int v;
	v = c * sensor_pkg::LANES + k + f % (1 << sensor_pkg::FRM_W);
	return v[sensor_pkg::PIX_W-1:0];
endfunction

// one word through CRC-10 MSB first
function automatic logic [sensor_pkg::PIX_W-1:0] crc10_word(
	input logic [sensor_pkg::PIX_W-1:0] crc_in,
	input logic [sensor_pkg::PIX_W-1:0] word
);
	int r;
	r = int'(crc_in);
	for (int b = sensor_pkg::PIX_W - 1; b >= 0; b--) begin
		// top bit leaving the register meets the data bit
		if ((((r >> (sensor_pkg::PIX_W - 1)) & 1) ^ int'(word[b])) != 0) begin
			r = ((r << 1) ^ int'(sensor_pkg::CRC_POLY)) & ((1 << sensor_pkg::PIX_W) - 1);
		end else begin
			r = (r << 1) & ((1 << sensor_pkg::PIX_W) - 1);
		end
	end
	return r[sensor_pkg::PIX_W-1:0];
endfunction

// control word at pixel column c of line l
function automatic logic [sensor_pkg::PIX_W-1:0] expected_code(input int c, input int l);
	if (c == 0) begin
		return (l == 0) ? sensor_pkg::FS : sensor_pkg::LS;
	end else if (c == 1 || c == exp_len - 1) begin
		return sensor_pkg::ID;
	end else if (c == exp_len - 2) begin
		return (l == exp_num - 1) ? sensor_pkg::FE : sensor_pkg::LE;
	end
	return sensor_pkg::IMG;
endfunction

task automatic pulse_start();
	i_start = 1'b1;
	@(posedge clk);
	#1;
	i_start = 1'b0;
endtask

// one frame where poke sends a second start halfway through
task automatic run_frame(input int len, input int num, input int hb, input bit poke);
	int frames_done;
	int slots_done;
	frames_done = frames_seen + 1;
	slots_done = crc_slots + num;
	exp_len = len;
	exp_num = num;
	exp_hb = hb;
	i_line_len = len[sensor_pkg::COL_W-1:0];
	i_line_num = num[sensor_pkg::ROW_W-1:0];
	i_hblank = hb[sensor_pkg::COL_W-1:0];
	pulse_start();
	check_value("busy after start", o_busy, 1'b1);
	if (poke) begin
		repeat (num * (len + hb) / 2) @(posedge clk);
		#1;
		check_value("busy at second start", o_busy, 1'b1);
		// other geometry that must not be taken either
		i_line_num = 10'd1;
		i_line_len = 10'd5;
		pulse_start();
	end
	// done once the frame end and every CRC slot went by
	while (frames_seen < frames_done || crc_slots < slots_done) begin
		@(posedge clk);
	end
	#1;
	check_value("busy after frame", o_busy, 1'b0);
endtask

task automatic idle_after_reset();
	repeat (3) begin
		check_value("busy in idle", o_busy, 1'b0);
		check_value("valids in idle", {o_video.fval, o_video.lval}, 2'b00);
		check_value("lanes in idle", |o_video.lanes, 1'b0);
		check_value("code in idle", o_video.ctrl, sensor_pkg::TR);
		@(posedge clk);
		#1;
	end
endtask

task automatic start_while_busy();
	run_frame(8, 4, 3, 1'b1);
	// monitor expects this frame one frame count further on
	run_frame(6, 3, 4, 1'b0);
endtask

task automatic random_geometries();
	int len;
	int num;
	int hb;
	for (int i = 0; i < 3; i++) begin
		len = 4 + int'($unsigned($random(seed)) % 17);
		num = 1 + int'($unsigned($random(seed)) % 5);
		hb = 3 + int'($unsigned($random(seed)) % 6);
		// last one pinned to a single line where FS and FE share it
		if (i == 2) begin
			num = 1;
		end
		$display("random frame %0d: line_len %0d, lines %0d, hblank %0d", i, len, num, hb);
		run_frame(len, num, hb, 1'b0);
	end
endtask

`endif

// File: sim/tb_sensor_video.sv
/*
  testbench for the four lane sensor video emulator
  directed frames plus three random geometries from seed 96
  a monitor checks every output cycle against model functions
  stops at the first mismatch or when the cycle budget runs out
*/

module tb_sensor_video;

	// frame cost is lines*(line_len+hblank)+10 cycles
	localparam int SMALL_CYC = 3 * (6 + 4) + 10;
	localparam int BUSY_CYC  = 4 * (8 + 3) + 10;
	localparam int RAND_CYC  = 5 * (20 + 8) + 10;
	localparam int LIMIT_CYC = 2 * SMALL_CYC + BUSY_CYC + 3 * RAND_CYC + 100;

	logic                               clk;
	logic                               i_rst_n;
	logic                               i_start;
	logic [sensor_pkg::COL_W-1:0]       i_line_len;
	logic [sensor_pkg::ROW_W-1:0]       i_line_num;
	logic [sensor_pkg::COL_W-1:0]       i_hblank;
	logic                               o_busy;
	sensor_pkg::video_t                 o_video;

	// geometry of the frame in flight
	int exp_len = 4;
	int exp_num = 1;
	int exp_hb = 3;
	// monitor state counted from the output valids
	logic mon_en = 1'b0;
	logic prev_fval = 1'b0;
	logic prev_lval = 1'b0;
	int mon_col = 0;
	int mon_line = 0;
	int mon_blank = 0;
	int frames_seen = 0;
	int crc_slots = 0;
	logic [sensor_pkg::LANES-1:0][sensor_pkg::PIX_W-1:0] crc_model = '0;
	int err_cnt = 0;
	int cycle_cnt = 0;
	int seed = 96;

	sensor_video_top u_sensor_video_top (
		.clk        (clk),
		.i_rst_n    (i_rst_n),
		.i_start    (i_start),
		.i_line_len (i_line_len),
		.i_line_num (i_line_num),
		.i_hblank   (i_hblank),
		.o_busy     (o_busy),
		.o_video    (o_video)
	);

	always #5 clk = ~clk;

	task automatic stop_run();
		$display("TEST FAILED");
		$fatal(1, "run stopped on failure");
	endtask

	`include "tb_tasks.svh"

	// cycle budget
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= LIMIT_CYC) begin
			$display("simulation timed out with tests unfinished after %0d cycles", cycle_cnt);
			stop_run();
		end
	end

	// ------------------------------
	// output monitor
	// ------------------------------
	// outputs change on the rising edge and are sampled on the falling one
	always @(negedge clk) begin
		logic [sensor_pkg::PIX_W-1:0] exp_word;
		if (mon_en) begin
			if (o_video.fval && !prev_fval) begin
				check_value("lval rise with fval", o_video.lval, 1'b1);
				mon_line = -1;
			end
			if (!o_video.fval && prev_fval) begin
				check_value("lval fall with fval", prev_lval & ~o_video.lval, 1'b1);
				check_value("lines in frame", mon_line + 1, exp_num);
				frames_seen++;
			end
			// CRC model restarts from the seed on each new line
			if (o_video.lval && !prev_lval) begin
				if (mon_line >= 0) begin
					check_value("hblank cycles", mon_blank, exp_hb);
				end
				mon_line++;
				mon_col = 0;
				crc_model = {sensor_pkg::LANES{sensor_pkg::CRC_INIT}};
			end
			if (o_video.lval) begin
				check_value("fval in line", o_video.fval, 1'b1);
				check_value($sformatf("code at line %0d col %0d", mon_line, mon_col),
					o_video.ctrl, expected_code(mon_col, mon_line));
				for (int k = 0; k < sensor_pkg::LANES; k++) begin
					exp_word = pattern_word(mon_col, k, frames_seen);
					check_value($sformatf("lane %0d at line %0d col %0d", k, mon_line, mon_col),
						o_video.lanes[k], exp_word);
					crc_model[k] = crc10_word(crc_model[k], exp_word);
				end
				mon_col++;
			end else if (prev_lval) begin
				// CRC slot is the first cycle after lval
				check_value("pixels in line", mon_col, exp_len);
				check_value("code after line", o_video.ctrl, sensor_pkg::CRC);
				for (int k = 0; k < sensor_pkg::LANES; k++) begin
					check_value($sformatf("CRC of lane %0d line %0d", k, mon_line),
						o_video.lanes[k], crc_model[k]);
				end
				mon_blank = 1;
				crc_slots++;
			end else begin
				check_value("code outside lines", o_video.ctrl, sensor_pkg::TR);
				check_value("lanes outside lines", |o_video.lanes, 1'b0);
				mon_blank++;
			end
			prev_fval = o_video.fval;
			prev_lval = o_video.lval;
		end
	end

	// ------------------------------
	// test sequence
	// ------------------------------
	initial begin
		clk = 1'b0;
		i_rst_n = 1'b0;
		i_start = 1'b0;
		i_line_len = 10'd4;
		i_line_num = 10'd1;
		i_hblank = 10'd3;
		repeat (4) @(posedge clk);
		#1;
		i_rst_n = 1'b1;
		mon_en = 1'b1;
		idle_after_reset();
		run_frame(6, 3, 4, 1'b0);
		start_while_busy();
		random_geometries();
		if (err_cnt == 0) begin
			$display("TEST OK");
			$finish;
		end else begin
			stop_run();
		end
	end

endmodule

// File: source/sensor_video_top.sv
/*
  four lane image sensor output emulator
  geometry levels are sampled on i_start while idle
  output lags the timing controller by 5 cycles
  no back-pressure, video can never stall
*/

module sensor_video_top (
	input  logic                                clk,
	input  logic                                i_rst_n,
	input  logic                                i_start,
	input  logic [sensor_pkg::COL_W-1:0]        i_line_len,
	input  logic [sensor_pkg::ROW_W-1:0]        i_line_num,
	input  logic [sensor_pkg::COL_W-1:0]        i_hblank,
	output logic                                o_busy,
	output sensor_pkg::video_t                  o_video
);

	// ------------------------------
	// internal buses
	// ------------------------------
	sensor_pkg::timing_t    timing_raw;
	sensor_pkg::timing_t    timing_pix;
	sensor_pkg::video_t     video_sync;

	// valids, column and frame count
	frame_timing_ctrl u_timing (
		.clk        (clk),
		.i_rst_n    (i_rst_n),
		.i_start    (i_start),
		.i_line_len (i_line_len),
		.i_line_num (i_line_num),
		.i_hblank   (i_hblank),
		.o_busy     (o_busy),
		.o_timing   (timing_raw)
	);

	// lanes filled, +1 cycle
	test_pattern_gen u_pattern (
		.clk        (clk),
		.i_rst_n    (i_rst_n),
		.i_timing   (timing_raw),
		.o_timing   (timing_pix)
	);

	// control lane codes, +3 cycles
	sync_code_insert u_insert (
		.clk        (clk),
		.i_rst_n    (i_rst_n),
		.i_timing   (timing_pix),
		.o_video    (video_sync)
	);

	// CRC slot fill, +1 cycle
	line_crc u_crc (
		.clk        (clk),
		.i_rst_n    (i_rst_n),
		.i_video    (video_sync),
		.o_video    (o_video)
	);

endmodule

// File: source/line_crc.sv
/*
  per lane CRC-10 over each line, one cycle latency
  seed is all ones at every lval rise, pixels go in MSB first
  in the CRC slot the lanes carry the CRC, otherwise they pass through
  relies on at least one blank cycle between lval fall and the next rise
*/

module line_crc (
	input  logic                    clk,
	input  logic                    i_rst_n,
	input  sensor_pkg::video_t      i_video,
	output sensor_pkg::video_t      o_video
);

	logic [sensor_pkg::LANES-1:0][sensor_pkg::PIX_W-1:0] crc_q;
	logic [sensor_pkg::LANES-1:0][sensor_pkg::PIX_W-1:0] crc_nxt;
	logic                                                lval_rise;

	// one pixel word through the CRC, bit serial
	function automatic logic [sensor_pkg::PIX_W-1:0] crc_step(
		input logic [sensor_pkg::PIX_W-1:0] crc_in,
		input logic [sensor_pkg::PIX_W-1:0] data
	);
		logic [sensor_pkg::PIX_W-1:0] crc;
		logic                         fb;
		crc = crc_in;
		for (int i = sensor_pkg::PIX_W - 1; i >= 0; i--) begin
			fb  = crc[sensor_pkg::PIX_W-1] ^ data[i];
			crc = {crc[sensor_pkg::PIX_W-2:0], 1'b0};
			if (fb) begin
				crc = crc ^ sensor_pkg::CRC_POLY;
			end
		end
		return crc;
	endfunction

	// output register doubles as previous lval
	assign lval_rise = i_video.lval & ~o_video.lval;

	// ------------------------------
	// CRC accumulate
	// ------------------------------
	always_comb begin
		for (int k = 0; k < sensor_pkg::LANES; k++) begin
			crc_nxt[k] = crc_step(lval_rise ? sensor_pkg::CRC_INIT : crc_q[k],
				i_video.lanes[k]);
		end
	end

	always_ff @(posedge clk) begin
		if (i_video.lval) begin
			crc_q <= crc_nxt;
		end
	end

	// ------------------------------
	// output and CRC substitution
	// ------------------------------
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_video.fval  <= 1'b0;
			o_video.lval  <= 1'b0;
			o_video.lanes <= '0;
			o_video.ctrl  <= sensor_pkg::TR;
		end else begin
			o_video.fval <= i_video.fval;
			o_video.lval <= i_video.lval;
			o_video.ctrl <= i_video.ctrl;
			if (i_video.ctrl == sensor_pkg::CRC) begin
				o_video.lanes <= crc_q;
			end else begin
				o_video.lanes <= i_video.lanes;
			end
		end
	end

endmodule

// File: source/sync_code_insert.sv
/*
  control lane sync code inserter
  fval, lval and lanes leave 3 cycles after they enter
  needs line_len >= 4 and hblank >= 3 so code slots never overlap
  FS/FE share a line when the frame has one line only
  CRC slot only marks the cycle, the CRC itself is added downstream
*/

module sync_code_insert (
	input  logic                    clk,
	input  logic                    i_rst_n,
	input  sensor_pkg::timing_t     i_timing,
	output sensor_pkg::video_t      o_video
);

	logic                           fval_d;
	logic                           lval_d;
	logic                           fval_rise;
	logic                           fval_fall;
	logic                           lval_rise;
	logic                           lval_fall;
	// strobe chains, index 0 is one cycle late
	logic [1:0]                     fval_rise_sr;
	logic [2:0]                     lval_rise_sr;
	logic [1:0]                     lval_fall_sr;
	// video delay line
	logic [2:0]                     fval_sr;
	logic [2:0]                     lval_sr;
	logic [2:0][sensor_pkg::LANES-1:0][sensor_pkg::PIX_W-1:0] lanes_sr;
	sensor_pkg::sync_code_e         ctrl_q;

	// ------------------------------
	// edge detect
	// ------------------------------
	assign fval_rise = i_timing.fval & ~fval_d;
	assign fval_fall = ~i_timing.fval & fval_d;
	assign lval_rise = i_timing.lval & ~lval_d;
	assign lval_fall = ~i_timing.lval & lval_d;

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			fval_d       <= 1'b0;
			lval_d       <= 1'b0;
			fval_rise_sr <= '0;
			lval_rise_sr <= '0;
			lval_fall_sr <= '0;
			fval_sr      <= '0;
			lval_sr      <= '0;
			lanes_sr     <= '0;
		end else begin
			fval_d       <= i_timing.fval;
			lval_d       <= i_timing.lval;
			fval_rise_sr <= {fval_rise_sr[0], fval_rise};
			lval_rise_sr <= {lval_rise_sr[1:0], lval_rise};
			lval_fall_sr <= {lval_fall_sr[0], lval_fall};
			fval_sr      <= {fval_sr[1:0], i_timing.fval};
			lval_sr      <= {lval_sr[1:0], i_timing.lval};
			lanes_sr     <= {lanes_sr[1:0], i_timing.lanes};
		end
	end

	// ------------------------------
	// code select
	// ------------------------------
	// decided one cycle before the word leaves, hence the odd offsets
	// lval_fall itself lines up with the second to last output pixel
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			ctrl_q <= sensor_pkg::TR;
		end else if (lval_rise_sr[1]) begin
			ctrl_q <= fval_rise_sr[1] ? sensor_pkg::FS : sensor_pkg::LS;
		end else if (lval_rise_sr[2]) begin
			ctrl_q <= sensor_pkg::ID;
		end else if (lval_fall) begin
			// last line, fval falls together with lval
			ctrl_q <= fval_fall ? sensor_pkg::FE : sensor_pkg::LE;
		end else if (lval_fall_sr[0]) begin
			ctrl_q <= sensor_pkg::ID;
		end else if (lval_fall_sr[1]) begin
			ctrl_q <= sensor_pkg::CRC;
		end else if (lval_sr[1]) begin
			ctrl_q <= sensor_pkg::IMG;
		end else begin
			ctrl_q <= sensor_pkg::TR;
		end
	end

	always_comb begin
		o_video.fval  = fval_sr[2];
		o_video.lval  = lval_sr[2];
		o_video.lanes = lanes_sr[2];
		o_video.ctrl  = ctrl_q;
	end

endmodule

// File: source/test_pattern_gen.sv
/*
  counting test pattern, one cycle latency
  lane k at column c of frame f = (c*4 + k + f) mod 1024
  lanes are forced to zero outside lval
*/

module test_pattern_gen (
	input  logic                    clk,
	input  logic                    i_rst_n,
	input  sensor_pkg::timing_t     i_timing,
	output sensor_pkg::timing_t     o_timing
);

	logic [sensor_pkg::LANES-1:0][sensor_pkg::PIX_W-1:0] lanes_nxt;

	// per lane value, upper bits wrap away
	always_comb begin
		int unsigned sum;
		for (int k = 0; k < sensor_pkg::LANES; k++) begin
			sum = i_timing.col * sensor_pkg::LANES + k + i_timing.frame;
			if (i_timing.lval) begin
				lanes_nxt[k] = sum[sensor_pkg::PIX_W-1:0];
			end else begin
				lanes_nxt[k] = '0;
			end
		end
	end

	// ------------------------------
	// output register
	// ------------------------------
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_timing <= '0;
		end else begin
			o_timing.fval  <= i_timing.fval;
			o_timing.lval  <= i_timing.lval;
			o_timing.col   <= i_timing.col;
			o_timing.frame <= i_timing.frame;
			o_timing.lanes <= lanes_nxt;
		end
	end

endmodule

// File: source/frame_timing_ctrl.sv
/*
  frame and line valid generator
  geometry is sampled only on a start strobe while idle
  line_len must be 4 or more, line_num 1 or more, hblank 3 or more
  a start strobe while busy is dropped, there is no queueing
  lanes of the timing output are always zero here
*/

module frame_timing_ctrl (
	input  logic                                clk,
	input  logic                                i_rst_n,
	input  logic                                i_start,
	input  logic [sensor_pkg::COL_W-1:0]        i_line_len,
	input  logic [sensor_pkg::ROW_W-1:0]        i_line_num,
	input  logic [sensor_pkg::COL_W-1:0]        i_hblank,
	output logic                                o_busy,
	output sensor_pkg::timing_t                 o_timing
);

	sensor_pkg::timing_state_e          state;
	logic [sensor_pkg::COL_W-1:0]       col_cnt;
	logic [sensor_pkg::COL_W-1:0]       blank_cnt;
	logic [sensor_pkg::ROW_W-1:0]       row_cnt;
	logic [sensor_pkg::FRM_W-1:0]       frame_cnt;
	logic [sensor_pkg::COL_W-1:0]       line_len_q;
	logic [sensor_pkg::ROW_W-1:0]       line_num_q;
	logic [sensor_pkg::COL_W-1:0]       hblank_q;
	logic                               start_ok;
	logic                               line_done;
	logic                               last_line;
	logic                               blank_done;

	assign start_ok   = (state == sensor_pkg::ST_IDLE) && i_start;
	assign line_done  = (col_cnt == line_len_q - 1'b1);
	assign last_line  = (row_cnt == line_num_q - 1'b1);
	assign blank_done = (blank_cnt == hblank_q - 1'b1);

	// geometry latch
	always_ff @(posedge clk) begin
		if (start_ok) begin
			line_len_q <= i_line_len;
			line_num_q <= i_line_num;
			hblank_q   <= i_hblank;
		end
	end

	// ------------------------------
	// state machine and counters
	// ------------------------------
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state     <= sensor_pkg::ST_IDLE;
			col_cnt   <= '0;
			blank_cnt <= '0;
			row_cnt   <= '0;
			frame_cnt <= '0;
		end else begin
			case (state)
				sensor_pkg::ST_IDLE: begin
					if (i_start) begin
						state   <= sensor_pkg::ST_LINE;
						col_cnt <= '0;
						row_cnt <= '0;
					end
				end
				sensor_pkg::ST_LINE: begin
					col_cnt <= col_cnt + 1'b1;
					if (line_done) begin
						// no blanking after the last line, fval drops with lval
						if (last_line) begin
							state     <= sensor_pkg::ST_IDLE;
							frame_cnt <= frame_cnt + 1'b1;
						end else begin
							state     <= sensor_pkg::ST_HBLANK;
							blank_cnt <= '0;
						end
					end
				end
				sensor_pkg::ST_HBLANK: begin
					blank_cnt <= blank_cnt + 1'b1;
					if (blank_done) begin
						state   <= sensor_pkg::ST_LINE;
						col_cnt <= '0;
						row_cnt <= row_cnt + 1'b1;
					end
				end
				default: state <= sensor_pkg::ST_IDLE;
			endcase
		end
	end

	// valids decode straight from state
	assign o_busy = (state != sensor_pkg::ST_IDLE);

	always_comb begin
		o_timing.fval  = (state != sensor_pkg::ST_IDLE);
		o_timing.lval  = (state == sensor_pkg::ST_LINE);
		o_timing.col   = col_cnt;
		o_timing.frame = frame_cnt;
		o_timing.lanes = '0;
	end

endmodule

// File: source/sensor_pkg.sv
/*
  shared types for the four-lane sensor video emulator
  fixed at 10-bit pixels and 4 data lanes, no run-time width change
  sync codes are the 10-bit set only, window and ID fields stay zero
  CRC-10 uses polynomial 0x233 with an all-ones seed, MSB first
*/

package sensor_pkg;

	// ------------------------------
	// widths
	// ------------------------------
	localparam int PIX_W = 10;
	localparam int LANES = 4;
	localparam int COL_W = 10;
	localparam int ROW_W = 10;
	localparam int FRM_W = 8;

	// x^10+x^9+x^5+x^4+x+1, x^10 implied
	localparam logic [PIX_W-1:0] CRC_POLY = 10'h233;
	localparam logic [PIX_W-1:0] CRC_INIT = 10'h3ff;

	// ------------------------------
	// control lane words
	// ------------------------------
	typedef enum logic [PIX_W-1:0] {
		TR  = 10'h3a6,
		FS  = 10'h2aa,
		FE  = 10'h32a,
		LS  = 10'h0aa,
		LE  = 10'h12a,
		IMG = 10'h035,
		CRC = 10'h059,
		ID  = 10'h000
	} sync_code_e;

	// frame timing controller states
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LINE,
		ST_HBLANK
	} timing_state_e;

	// ------------------------------
	// video buses
	// ------------------------------
	// raw timing plus lane payload, 60 bits
	typedef struct packed {
		logic                          fval;
		logic                          lval;
		logic [COL_W-1:0]              col;
		logic [FRM_W-1:0]              frame;
		logic [LANES-1:0][PIX_W-1:0]   lanes;
	} timing_t;

	// sensor output, lanes plus control lane word
	typedef struct packed {
		logic                          fval;
		logic                          lval;
		logic [LANES-1:0][PIX_W-1:0]   lanes;
		sync_code_e                    ctrl;
	} video_t;

endpackage
